// ==== vlog.f ====
+incdir+tb
common/mem_pkg.sv
design/ims1403_sram.sv
ram_bank/ram_bank.sv
design/mem_bus_ctrl.sv
design/mem_array_top.sv
tb/tb_mem_array.sv

// ==== Makefile ====
# Verilator build and run of the memory array testbench
VERILATOR ?= verilator
TOP       ?= tb_mem_array
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# The log search decides the exit status
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_mem_vectors.svh ====
// Vector table for the memory array testbench, included inside the testbench module only
`ifndef TB_MEM_VECTORS_SVH
`define TB_MEM_VECTORS_SVH

localparam int RANDOM_OPS   = 200;  // Length of the random section
localparam int RESET_CYCLES = 5;    // Reset length, start and mid-run

// Test identifiers, printed through test_name()
localparam logic [2:0] T_RESET_CLEAR = 3'd0;
localparam logic [2:0] T_WRITE_READ  = 3'd1;
localparam logic [2:0] T_BANK        = 3'd2;
localparam logic [2:0] T_LANE        = 3'd3;
localparam logic [2:0] T_RANDOM      = 3'd4;
localparam logic [2:0] T_RESET_MID   = 3'd5;

// One table entry, applied in one clock cycle
typedef struct packed {
   logic [2:0]        test_id;   // Which test owns this entry
   logic              rst;       // Hold reset_n low this cycle
   logic              req;       // Request strobe
   logic              we;        // 1 write, 0 read
   logic [ADDR_W-1:0] addr;      // Full bus address
   logic [DATA_W-1:0] wdata;     // Write byte
   logic [DATA_W-1:0] exp_byte;  // Expected read byte
   logic              use_exp;   // 1 table value, 0 model value
} vec_t;

vec_t        vectors [$];  // Whole run, built at time zero
logic [31:0] lcg_state;    // Random generator state

function automatic string test_name(input logic [2:0] id);
   case (id)
      T_RESET_CLEAR: return "reset_clear";
      T_WRITE_READ:  return "write_read";
      T_BANK:        return "bank_indep";
      T_LANE:        return "lane_indep";
      T_RANDOM:      return "random_mix";
      T_RESET_MID:   return "reset_mid";
      default:       return "unknown";
   endcase
endfunction

// Multiplier and increment of the common 32-bit LCG, modulo 2^32
function automatic logic [31:0] lcg_step(input logic [31:0] s);
   return s * 32'd1103515245 + 32'd12345;
endfunction

task automatic push_vector(input logic [2:0] id, input logic rst, input logic req,
                           input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata,
                           input logic [DATA_W-1:0] exp_byte, input logic use_exp);
   vec_t v;
   v = '{test_id: id, rst: rst, req: req, we: we, addr: addr, wdata: wdata,
         exp_byte: exp_byte, use_exp: use_exp};
   vectors.push_back(v);
endtask

task automatic add_write(input logic [2:0] id, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data);
   push_vector(id, 1'b0, 1'b1, 1'b1, addr, data, 8'h00, 1'b0);
endtask

// Read with a fixed expected byte
task automatic add_read(input logic [2:0] id, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] exp_byte);
   push_vector(id, 1'b0, 1'b1, 1'b0, addr, 8'h00, exp_byte, 1'b1);
endtask

task automatic add_model_read(input logic [2:0] id, input logic [ADDR_W-1:0] addr);
   push_vector(id, 1'b0, 1'b1, 1'b0, addr, 8'h00, 8'h00, 1'b0);  // Model decides
endtask

task automatic add_idle(input logic [2:0] id);
   push_vector(id, 1'b0, 1'b0, 1'b0, '0, 8'h00, 8'h00, 1'b0);
endtask

// Reset cycle carrying a write, which reset must override
task automatic add_reset_cycle(input logic [2:0] id, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
   push_vector(id, 1'b1, 1'b1, 1'b1, addr, data, 8'h00, 1'b0);
endtask

task automatic build_vectors();
   logic [ADDR_W-1:0] saved [$];  // Random write addresses, reread after reset
   logic [ADDR_W-1:0] a;
   logic [DATA_W-1:0] b;
   logic [31:0]       r;
   lcg_state = 32'd14;                             // Fixed seed
   // Reset leaves zero everywhere, last location of each chip included
   add_read(T_RESET_CLEAR, 15'h0000, 8'h00);
   add_read(T_RESET_CLEAR, 15'h3FFF, 8'h00);      // Top of bank 0
   add_read(T_RESET_CLEAR, 15'h4000, 8'h00);      // Bottom of bank 1
   add_read(T_RESET_CLEAR, 15'h7FFF, 8'h00);      // Top of bank 1
   add_write(T_WRITE_READ, 15'h0123, 8'hA5);
   add_read(T_WRITE_READ, 15'h0123, 8'hA5);       // Cycle right after the write
   add_write(T_WRITE_READ, 15'h4ABC, 8'h3C);
   add_idle(T_WRITE_READ);
   add_read(T_WRITE_READ, 15'h4ABC, 8'h3C);
   add_write(T_WRITE_READ, 15'h7FFF, 8'h81);
   add_read(T_WRITE_READ, 15'h7FFF, 8'h81);
   add_read(T_WRITE_READ, 15'h0123, 8'hA5);       // Back-to-back reads
   add_write(T_BANK, 15'h0055, 8'h11);            // Same chip address, two banks
   add_write(T_BANK, 15'h4055, 8'hEE);
   add_read(T_BANK, 15'h0055, 8'h11);
   add_read(T_BANK, 15'h4055, 8'hEE);
   for (int k = 0; k < DATA_W; k++) begin
      add_write(T_LANE, 15'h0200 + 15'(k), 8'h01 << k);     // Walking one
      add_write(T_LANE, 15'h4200 + 15'(k), ~(8'h01 << k));  // Walking zero
   end
   for (int k = 0; k < DATA_W; k++) begin
      add_read(T_LANE, 15'h0200 + 15'(k), 8'h01 << k);
      add_read(T_LANE, 15'h4200 + 15'(k), ~(8'h01 << k));
   end
   // Small address window per bank so that reads often hit written bytes
   for (int n = 0; n < RANDOM_OPS; n++) begin
      lcg_state = lcg_step(lcg_state);
      r = lcg_state;
      a = {r[30], 8'h03, r[29:24]};               // Bank bit, 64 locations each
      if (r[31]) begin
         lcg_state = lcg_step(lcg_state);
         b = lcg_state[31:24];                    // Upper bits, better spread
         add_write(T_RANDOM, a, b);
         if (saved.size() < 4) begin
            saved.push_back(a);
         end
      end else begin
         add_model_read(T_RANDOM, a);
      end
   end
   for (int k = 0; k < RESET_CYCLES; k++) begin
      add_reset_cycle(T_RESET_MID, k[0] ? 15'h7FFF : 15'h0123, 8'hFF);  // Lost to reset
   end
   add_read(T_RESET_MID, 15'h0123, 8'h00);        // Written earlier, now cleared
   add_read(T_RESET_MID, 15'h4055, 8'h00);
   add_read(T_RESET_MID, 15'h7FFF, 8'h00);
   foreach (saved[k]) begin
      add_read(T_RESET_MID, saved[k], 8'h00);
   end
   add_write(T_RESET_MID, 15'h0123, 8'h5A);       // Array usable again
   add_read(T_RESET_MID, 15'h0123, 8'h5A);
endtask

`endif

// ==== tb/tb_mem_array.sv ====
// Self-checking testbench, a read result is checked one clock after its request and rvalid every cycle
`default_nettype none

module tb_mem_array
   import mem_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

`include "tb_mem_vectors.svh"

   logic              clk;       // 40 ns period
   logic              reset_n;   // Sync reset, active low
   logic              req;       // Request strobe to DUT
   mem_req_t          req_data;  // Request payload to DUT
   logic [DATA_W-1:0] rdata;     // Read byte from DUT
   logic              rvalid;    // Read valid from DUT

   logic [DATA_W-1:0] model_mem [0:(1<<ADDR_W)-1];  // Reference contents

   int cycles       = 0;  // Clock edges so far
   int max_cycles   = 0;  // Timeout limit, set once the table is built
   int total_errors = 0;
   int total_checks = 0;
   int test_errors  = 0;
   int test_checks  = 0;

   logic              pend_valid;  // Read in flight, result due next check
   logic [DATA_W-1:0] pend_exp;    // Expected byte for that read
   logic [ADDR_W-1:0] pend_addr;   // Its address, for messages
   logic [2:0]        pend_test;   // Its test
   logic [2:0]        cur_test;    // Test now being applied

   initial clk = 1'b0;
   always #20 clk = ~clk;

   mem_array_top u_dut (
      .clk      (clk),
      .reset_n  (reset_n),
      .req      (req),
      .req_data (req_data),
      .rdata    (rdata),
      .rvalid   (rvalid)
   );

   // Ends a run that has stopped making progress
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > max_cycles) begin
         $display("Timeout: run went past %0d cycles without finishing", max_cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic compare_byte(input logic [2:0] id, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
      test_checks++;
      if (actual !== expected) begin
         $display("MISMATCH test=%s expected=%02h actual=%02h addr=%04h time=%0t",
                  test_name(id), expected, actual, addr, $time);
         test_errors++;
      end
   endtask

   // rvalid must match the pending read exactly
   task automatic check_response();
      if (rvalid !== pend_valid) begin
         if (pend_valid) begin
            $display("Test %s: no rvalid for the read of %04h at %0t",
                     test_name(pend_test), pend_addr, $time);
         end else begin
            $display("Test %s: rvalid high with no read in flight at %0t",
                     test_name(cur_test), $time);
         end
         test_errors++;
      end else if (pend_valid) begin
         compare_byte(pend_test, pend_addr, pend_exp, rdata);
      end
   endtask

   task automatic clear_model();
      for (int i = 0; i < (1 << ADDR_W); i++) begin
         model_mem[i] = '0;
      end
   endtask

   task automatic report_test();
      $display("Test %-12s %0d reads checked, %0d errors", test_name(cur_test),
               test_checks, test_errors);
      total_errors += test_errors;
      total_checks += test_checks;
      test_errors = 0;
      test_checks = 0;
   endtask

   // One entry per clock, outputs sampled at the falling edge
   task automatic apply_vector(input vec_t v);
      @(posedge clk);
      reset_n  <= !v.rst;
      req      <= v.req;
      req_data <= '{addr: v.addr, wdata: v.wdata, we: v.we};
      @(negedge clk);
      check_response();                                     // Result of the previous entry
      if (v.test_id != cur_test) begin
         report_test();
         cur_test = v.test_id;
      end
      if (v.rst) begin
         clear_model();                                     // Reset beats any request
         pend_valid = 1'b0;
      end else if (v.req && v.we) begin
         model_mem[v.addr] = v.wdata;
         pend_valid = 1'b0;                                 // Writes return nothing
      end else if (v.req) begin
         pend_valid = 1'b1;
         pend_exp   = v.use_exp ? v.exp_byte : model_mem[v.addr];
         pend_addr  = v.addr;
         pend_test  = v.test_id;
      end else begin
         pend_valid = 1'b0;
      end
   endtask

   initial begin
      vec_t tail;
      reset_n    = 1'b0;
      req        = 1'b0;
      req_data   = '0;
      pend_valid = 1'b0;
      pend_exp   = '0;
      pend_addr  = '0;
      pend_test  = '0;
      build_vectors();
      max_cycles = vectors.size() + RESET_CYCLES + 50;
      clear_model();
      cur_test = vectors[0].test_id;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_n <= 1'b1;                                      // Released after 5 reset edges
      foreach (vectors[i]) begin
         apply_vector(vectors[i]);
      end
      tail = '0;
      tail.test_id = cur_test;                              // Idle cycle drains the last read
      apply_vector(tail);
      report_test();
      $display("Totals: %0d vectors, %0d reads checked, %0d errors", vectors.size(),
               total_checks, total_errors);
      if (total_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule : tb_mem_array

`default_nettype wire

// ==== design/mem_array_top.sv ====
// 32K x 8 array of two banks behind the bus controller, plain outputs with no tristate bus
`default_nettype none

module mem_array_top
   import mem_pkg::*;
(
   input  logic              clk,       // System clock
   input  logic              reset_n,   // Sync reset, clears all memory
   input  logic              req,       // Request strobe
   input  mem_req_t          req_data,  // Request payload
   output logic [DATA_W-1:0] rdata,     // Read byte
   output logic              rvalid     // Read valid, one clock after request
);

   chip_ctrl_t        bank_ctrl [NUM_BANKS];  // Controller to banks
   logic [DATA_W-1:0] bank_wdata;             // Shared write byte
   logic [DATA_W-1:0] bank_q [NUM_BANKS];     // Banks to controller

   // Decode and read return
   mem_bus_ctrl u_ctrl (
      .clk        (clk),
      .reset_n    (reset_n),
      .req        (req),
      .req_data   (req_data),
      .bank_ctrl  (bank_ctrl),
      .bank_wdata (bank_wdata),
      .bank_q     (bank_q),
      .rdata      (rdata),
      .rvalid     (rvalid)
   );

   // Bank 0 holds the low 16K, bank 1 the high 16K
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      ram_bank u_bank (
         .clk     (clk),
         .reset_n (reset_n),
         .ctrl    (bank_ctrl[b]),  // Own enable, shared address
         .wdata   (bank_wdata),
         .q       (bank_q[b])
      );
   end : g_bank

endmodule : mem_array_top

`default_nettype wire

// ==== design/mem_bus_ctrl.sv ====
// Decodes one request per cycle with no back-pressure, read data returns one clock later
`default_nettype none

module mem_bus_ctrl
   import mem_pkg::*;
(
   input  logic              clk,                   // Bus clock
   input  logic              reset_n,               // Sync reset, clears read tracking
   input  logic              req,                   // One-cycle request strobe
   input  mem_req_t          req_data,              // Address, data, direction
   output chip_ctrl_t        bank_ctrl [NUM_BANKS], // Per-bank address and strobes
   output logic [DATA_W-1:0] bank_wdata,            // Write byte shared by both banks
   input  logic [DATA_W-1:0] bank_q [NUM_BANKS],    // Read bytes from the banks
   output logic [DATA_W-1:0] rdata,                 // Selected read byte
   output logic              rvalid                 // Read data valid pulse
);

   logic [BANK_W-1:0]      req_bank;       // Bank addressed by this request
   logic [CHIP_ADDR_W-1:0] req_chip_addr;  // Location inside each chip
   logic                   rd_req;         // Read accepted this cycle
   logic [BANK_W-1:0]      rd_bank;        // Bank of the last read

   // Address split, bank on top
   assign req_bank      = req_data.addr[ADDR_W-1 -: BANK_W];
   assign req_chip_addr = req_data.addr[CHIP_ADDR_W-1:0];
   assign rd_req        = req && !req_data.we;  // Only reads return data

   // Chip control per bank
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_ctrl[b].address = req_chip_addr;                      // Shared chip address
         bank_ctrl[b].ce_n    = !(req && (req_bank == BANK_W'(b))); // Addressed bank only
         bank_ctrl[b].w_n     = !req_data.we;                       // Low on writes
      end
   end

   assign bank_wdata = req_data.wdata;  // Non-selected bank ignores it

   // Read tracking, one stage matches the chip read register
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rvalid  <= 1'b0;               // No read in flight
         rd_bank <= '0;                 // Back to bank 0
      end else begin
         rvalid <= rd_req;              // Pulse in the cycle after the read
         if (rd_req) begin
            rd_bank <= req_bank;        // Kept until the next read
         end
      end
   end

   // Bank q holds between reads, so rdata keeps the last byte
   assign rdata = bank_q[rd_bank];

endmodule : mem_bus_ctrl

`default_nettype wire

// ==== ram_bank/ram_bank.sv ====
// One 16K x 8 bank from eight 1-bit chips on a common address, all chips selected together
`default_nettype none

module ram_bank
   import mem_pkg::*;
(
   input  logic              clk,      // Bank clock
   input  logic              reset_n,  // Sync reset to every chip
   input  chip_ctrl_t        ctrl,     // Address and strobes, fanned out
   input  logic [DATA_W-1:0] wdata,    // Write byte, one bit per chip
   output logic [DATA_W-1:0] q         // Read byte, bit i from chip i
);

   // Bit lane i lives entirely in chip i
   for (genvar i = 0; i < DATA_W; i++) begin : g_chip
      ims1403_sram u_chip (
         .clk     (clk),
         .reset_n (reset_n),
         .ctrl    (ctrl),       // Same control for every lane
         .d       (wdata[i]),   // Own data bit
         .q       (q[i])        // Own output bit
      );
   end : g_chip

endmodule : ram_bank

`default_nettype wire

// ==== design/ims1403_sram.sv ====
// 16K x 1 chip model with plain output, no access timing, reset clears every location and wins
`default_nettype none

module ims1403_sram
   import mem_pkg::*;
(
   input  logic       clk,      // Single clock for all accesses
   input  logic       reset_n,  // Sync reset, clears array
   input  chip_ctrl_t ctrl,     // Shared bank control
   input  logic       d,        // Write data bit
   output logic       q         // Registered read bit
);

   logic [CHIP_DEPTH-1:0] mem_bits;  // Storage, one bit per location
   logic                  wr_en;     // Enabled write this cycle
   logic                  rd_en;     // Enabled read this cycle

   // Access decode from the active-low strobes
   assign wr_en = !ctrl.ce_n && !ctrl.w_n;  // Selected, write low
   assign rd_en = !ctrl.ce_n &&  ctrl.w_n;  // Selected, write high

   // Storage array
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mem_bits <= '0;                          // All 16384 locations, last included
      end else if (wr_en) begin
         mem_bits[ctrl.address] <= d;             // Store one bit
      end
   end

   // Read register holds until the next read of this chip
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         q <= 1'b0;                               // Output clears with the array
      end else if (rd_en) begin
         q <= mem_bits[ctrl.address];             // Old contents, writes excluded
      end
   end

endmodule : ims1403_sram

`default_nettype wire

// ==== common/mem_pkg.sv ====
// Geometry is fixed at 32K x 8 built from 16K x 1 chips, and the widths below must stay consistent
`default_nettype none

package mem_pkg;

   // Array geometry
   localparam int ADDR_W      = 15;                    // Bus address, 32K locations
   localparam int CHIP_ADDR_W = 14;                    // One chip holds 16K bits
   localparam int DATA_W      = 8;                     // Byte wide, also chips per bank
   localparam int NUM_BANKS   = 2;                     // Two banks of eight chips
   localparam int CHIP_DEPTH  = 16384;                 // Locations per chip
   localparam int BANK_W      = ADDR_W - CHIP_ADDR_W;  // Bank select from top address bits

   // One bus request, valid while req is high
   typedef struct packed {
      logic [ADDR_W-1:0] addr;                         // Bank in MSB, chip address below
      logic [DATA_W-1:0] wdata;                        // Write byte, ignored on reads
      logic              we;                           // 1 write, 0 read
   } mem_req_t;

   // Signals shared by every chip of one bank
   typedef struct packed {
      logic [CHIP_ADDR_W-1:0] address;                 // Bit location inside the chip
      logic                   ce_n;                    // Chip enable, active low
      logic                   w_n;                     // Write enable, active low
   } chip_ctrl_t;

endpackage : mem_pkg

`default_nettype wire
